// File: run_sim.sh
#!/bin/sh
# Build the MPU testbench with Verilator, run it and scan the log

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f verilog.f --top-module tb_mpu_top -o vsim \
  && ./obj_dir/vsim > sim.log 2>&1 \
  || echo "Something failed" >> sim.log
cat sim.log
grep -q "Something failed" sim.log && exit 1 || exit 0

// File: source/bus_arbiter.sv
`default_nettype none

module bus_arbiter import mpu_bus_pkg::*; #(
  parameter int ADDR_W = 32
) (
  input  logic              clk,
  input  logic              rst_n,

  // Instruction fetch port
  input  logic              if_req_i,
  input  logic [ADDR_W-1:0] if_addr_i,
  input  logic              if_we_i,
  input  logic              if_dbg_i,
  input  memtype_t          if_memtype_i,
  output logic              if_gnt_o,

  // Load/store port
  input  logic              lsu_req_i,
  input  logic [ADDR_W-1:0] lsu_addr_i,
  input  logic              lsu_we_i,
  input  logic              lsu_dbg_i,
  input  memtype_t          lsu_memtype_i,
  output logic              lsu_gnt_o,

  // Shared bus
  output logic              bus_req_o,
  output logic [ADDR_W-1:0] bus_addr_o,
  output logic              bus_we_o,
  output logic              bus_dbg_o,
  output memtype_t          bus_memtype_o,
  input  logic              bus_gnt_i
);

  arb_owner_e owner;
  arb_owner_e owner_q;
  arb_owner_e last_q;
  logic       lock_q;

  // Pick the owner; a pending request keeps it until granted
  always_comb begin
    if (lock_q) begin
      owner = owner_q;
    end else if (if_req_i && lsu_req_i) begin
      owner = (last_q == ARB_IF) ? ARB_LSU : ARB_IF;
    end else if (if_req_i) begin
      owner = ARB_IF;
    end else begin
      owner = ARB_LSU;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lock_q  <= 1'b0;
      owner_q <= ARB_IF;
      last_q  <= ARB_IF;  // LSU wins the first tie
    end else begin
      lock_q <= bus_req_o && !bus_gnt_i;
      if (bus_req_o && !lock_q) begin
        owner_q <= owner;
      end
      if (bus_req_o && bus_gnt_i) begin
        last_q <= owner;
      end
    end
  end

  // Winner's fields onto the bus
  assign bus_req_o     = (owner == ARB_LSU) ? lsu_req_i     : if_req_i;
  assign bus_addr_o    = (owner == ARB_LSU) ? lsu_addr_i    : if_addr_i;
  assign bus_we_o      = (owner == ARB_LSU) ? lsu_we_i      : if_we_i;
  assign bus_dbg_o     = (owner == ARB_LSU) ? lsu_dbg_i     : if_dbg_i;
  assign bus_memtype_o = (owner == ARB_LSU) ? lsu_memtype_i : if_memtype_i;

  assign if_gnt_o  = (owner == ARB_IF)  && if_req_i  && bus_gnt_i;
  assign lsu_gnt_o = (owner == ARB_LSU) && lsu_req_i && bus_gnt_i;

endmodule

`default_nettype wire

// File: source/mpu_bus_pkg.sv
`default_nettype none

// Port FSM, arbiter and bus attribute definitions
package mpu_bus_pkg;

  // Error response FSM of one port
  typedef enum logic {
    MPU_IDLE,
    MPU_ERR_RESP
  } mpu_state_e;

  // Bus owner, also used for the round-robin history
  typedef enum logic {
    ARB_IF,
    ARB_LSU
  } arb_owner_e;

  //////////////////////////////////////////////////////////////////////
  // Memory type on the bus
  //////////////////////////////////////////////////////////////////////

  typedef logic [1:0] memtype_t;

  localparam int MEMTYPE_BUF_BIT   = 0;
  localparam int MEMTYPE_CACHE_BIT = 1;

endpackage

`default_nettype wire

// File: source/mpu_pma_pkg.sv
`default_nettype none

// Physical memory attribute table and address definitions
package mpu_pma_pkg;

  //////////////////////////////////////////////////////////////////////
  // Addresses
  //////////////////////////////////////////////////////////////////////

  localparam int ADDR_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;

  //////////////////////////////////////////////////////////////////////
  // Region table
  //////////////////////////////////////////////////////////////////////

  localparam int PMA_NUM_REGIONS = 4;

  // Low bound inclusive, high bound exclusive
  localparam addr_t PMA_LOW [PMA_NUM_REGIONS] = '{
    32'h0000_0000,
    32'h1000_0000,
    32'h2000_0000,
    32'h0000_8000
  };

  localparam addr_t PMA_HIGH [PMA_NUM_REGIONS] = '{
    32'h0001_0000,
    32'h1001_0000,
    32'h3000_0000,
    32'h0001_8000
  };

  // Region 3 overlaps region 0 and only wins above 0x0001_0000
  localparam logic PMA_MAIN       [PMA_NUM_REGIONS] = '{1'b1, 1'b0, 1'b1, 1'b0};
  localparam logic PMA_BUFFERABLE [PMA_NUM_REGIONS] = '{1'b0, 1'b0, 1'b1, 1'b0};
  localparam logic PMA_CACHEABLE  [PMA_NUM_REGIONS] = '{1'b1, 1'b0, 1'b1, 1'b0};

  //////////////////////////////////////////////////////////////////////
  // Debug module window, both bounds inclusive
  //////////////////////////////////////////////////////////////////////

  localparam addr_t DM_REGION_START = 32'hF000_0000;
  localparam addr_t DM_REGION_END   = 32'hF000_3FFF;

endpackage

`default_nettype wire

// File: source/mpu_port.sv
`default_nettype none

module mpu_port import mpu_pma_pkg::*, mpu_bus_pkg::*; #(
  parameter int unsigned IS_INSTR_SIDE = 0
) (
  input  logic     clk,
  input  logic     rst_n,

  // Core side
  input  logic     req_i,
  input  addr_t    addr_i,
  input  logic     we_i,
  input  logic     dbg_i,
  input  logic     misaligned_i,
  output logic     gnt_o,
  output logic     err_o,

  // Towards the arbiter
  output logic     acc_req_o,
  output addr_t    acc_addr_o,
  output logic     acc_we_o,
  output logic     acc_dbg_o,
  output memtype_t acc_memtype_o,
  input  logic     acc_gnt_i
);

  localparam logic INSTR_SIDE = (IS_INSTR_SIDE != 0);

  mpu_state_e state_q;
  mpu_state_e state_d;

  logic pma_main;
  logic pma_bufferable;
  logic pma_cacheable;
  logic pma_err;

  pma_lookup u_pma_lookup (
    .addr_i       (addr_i),
    .dbg_i        (dbg_i),
    .instr_i      (INSTR_SIDE),
    .misaligned_i (misaligned_i),
    .main_o       (pma_main),
    .bufferable_o (pma_bufferable),
    .cacheable_o  (pma_cacheable),
    .err_o        (pma_err)
  );

  //////////////////////////////////////////////////////////////////////
  // Error response FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MPU_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d   = state_q;
    gnt_o     = 1'b0;
    acc_req_o = 1'b0;

    case (state_q)
      MPU_IDLE: begin
        if (req_i && pma_err) begin
          // Accept locally, the bus never sees it
          gnt_o   = 1'b1;
          state_d = MPU_ERR_RESP;
        end else begin
          acc_req_o = req_i;
          gnt_o     = req_i && acc_gnt_i;
        end
      end
      MPU_ERR_RESP: begin
        // Core is blocked while the error is returned
        state_d = MPU_IDLE;
      end
      default: begin
        state_d = MPU_IDLE;
      end
    endcase
  end

  assign err_o = (state_q == MPU_ERR_RESP);

  //////////////////////////////////////////////////////////////////////
  // Forwarded request fields
  //////////////////////////////////////////////////////////////////////

  assign acc_addr_o = addr_i;
  assign acc_we_o   = we_i;
  assign acc_dbg_o  = dbg_i;

  // Bufferable only for data stores, and never outside main memory
  assign acc_memtype_o[MEMTYPE_BUF_BIT]   = !INSTR_SIDE && we_i && pma_main && pma_bufferable;
  assign acc_memtype_o[MEMTYPE_CACHE_BIT] = pma_cacheable;

endmodule

`default_nettype wire

// File: source/mpu_top.sv
`default_nettype none

module mpu_top import mpu_pma_pkg::*, mpu_bus_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,

  // Instruction fetch side
  input  logic     if_req_i,
  input  addr_t    if_addr_i,
  input  logic     if_dbg_i,
  output logic     if_gnt_o,
  output logic     if_err_o,

  // Load/store side
  input  logic     lsu_req_i,
  input  addr_t    lsu_addr_i,
  input  logic     lsu_we_i,
  input  logic     lsu_dbg_i,
  input  logic     lsu_misaligned_i,
  output logic     lsu_gnt_o,
  output logic     lsu_err_o,

  // Shared bus
  output logic     bus_req_o,
  output addr_t    bus_addr_o,
  output logic     bus_we_o,
  output logic     bus_dbg_o,
  output memtype_t bus_memtype_o,
  input  logic     bus_gnt_i
);

  logic     if_acc_req;
  addr_t    if_acc_addr;
  logic     if_acc_we;
  logic     if_acc_dbg;
  memtype_t if_acc_memtype;
  logic     if_acc_gnt;

  logic     lsu_acc_req;
  addr_t    lsu_acc_addr;
  logic     lsu_acc_we;
  logic     lsu_acc_dbg;
  memtype_t lsu_acc_memtype;
  logic     lsu_acc_gnt;

  //////////////////////////////////////////////////////////////////////
  // Ports
  //////////////////////////////////////////////////////////////////////

  // Fetches never write and are never misaligned
  mpu_port #(
    .IS_INSTR_SIDE (1)
  ) u_if_port (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (if_req_i),
    .addr_i        (if_addr_i),
    .we_i          (1'b0),
    .dbg_i         (if_dbg_i),
    .misaligned_i  (1'b0),
    .gnt_o         (if_gnt_o),
    .err_o         (if_err_o),
    .acc_req_o     (if_acc_req),
    .acc_addr_o    (if_acc_addr),
    .acc_we_o      (if_acc_we),
    .acc_dbg_o     (if_acc_dbg),
    .acc_memtype_o (if_acc_memtype),
    .acc_gnt_i     (if_acc_gnt)
  );

  mpu_port #(
    .IS_INSTR_SIDE (0)
  ) u_lsu_port (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (lsu_req_i),
    .addr_i        (lsu_addr_i),
    .we_i          (lsu_we_i),
    .dbg_i         (lsu_dbg_i),
    .misaligned_i  (lsu_misaligned_i),
    .gnt_o         (lsu_gnt_o),
    .err_o         (lsu_err_o),
    .acc_req_o     (lsu_acc_req),
    .acc_addr_o    (lsu_acc_addr),
    .acc_we_o      (lsu_acc_we),
    .acc_dbg_o     (lsu_acc_dbg),
    .acc_memtype_o (lsu_acc_memtype),
    .acc_gnt_i     (lsu_acc_gnt)
  );

  //////////////////////////////////////////////////////////////////////
  // Arbiter
  //////////////////////////////////////////////////////////////////////

  bus_arbiter #(
    .ADDR_W (ADDR_W)
  ) u_bus_arbiter (
    .clk           (clk),
    .rst_n         (rst_n),
    .if_req_i      (if_acc_req),
    .if_addr_i     (if_acc_addr),
    .if_we_i       (if_acc_we),
    .if_dbg_i      (if_acc_dbg),
    .if_memtype_i  (if_acc_memtype),
    .if_gnt_o      (if_acc_gnt),
    .lsu_req_i     (lsu_acc_req),
    .lsu_addr_i    (lsu_acc_addr),
    .lsu_we_i      (lsu_acc_we),
    .lsu_dbg_i     (lsu_acc_dbg),
    .lsu_memtype_i (lsu_acc_memtype),
    .lsu_gnt_o     (lsu_acc_gnt),
    .bus_req_o     (bus_req_o),
    .bus_addr_o    (bus_addr_o),
    .bus_we_o      (bus_we_o),
    .bus_dbg_o     (bus_dbg_o),
    .bus_memtype_o (bus_memtype_o),
    .bus_gnt_i     (bus_gnt_i)
  );

endmodule

`default_nettype wire

// File: source/pma_lookup.sv
`default_nettype none

module pma_lookup import mpu_pma_pkg::*; (
  input  addr_t addr_i,
  input  logic  dbg_i,
  input  logic  instr_i,
  input  logic  misaligned_i,

  output logic  main_o,
  output logic  bufferable_o,
  output logic  cacheable_o,
  output logic  err_o
);

  logic [ADDR_W-3:0] word_addr;
  logic              matched;
  logic              dm_hit;
  logic              region_main;
  logic              region_bufferable;
  logic              region_cacheable;

  // Byte offset plays no part in region matching
  assign word_addr = addr_i[ADDR_W-1:2];

  assign dm_hit = dbg_i && (addr_i >= DM_REGION_START) && (addr_i <= DM_REGION_END);

  //////////////////////////////////////////////////////////////////////
  // Region scan
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    matched           = 1'b0;
    region_main       = 1'b0;
    region_bufferable = 1'b0;
    region_cacheable  = 1'b0;

    // Lowest index takes priority on overlap
    for (int i = 0; i < PMA_NUM_REGIONS; i++) begin
      if (!matched &&
          (word_addr >= PMA_LOW[i][ADDR_W-1:2]) &&
          (word_addr <  PMA_HIGH[i][ADDR_W-1:2])) begin
        matched           = 1'b1;
        region_main       = PMA_MAIN[i];
        region_bufferable = PMA_BUFFERABLE[i];
        region_cacheable  = PMA_CACHEABLE[i];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Debug override and error decision
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (dm_hit) begin
      // Plain main memory for the debug module
      main_o       = 1'b1;
      bufferable_o = 1'b0;
      cacheable_o  = 1'b0;
    end else begin
      main_o       = region_main;
      bufferable_o = region_bufferable;
      cacheable_o  = region_cacheable;
    end
  end

  // Fetches and misaligned accesses need main memory
  assign err_o = !main_o && (instr_i || misaligned_i);

endmodule

`default_nettype wire

// File: tb/mpu_checker.sv
`default_nettype none

module mpu_checker import mpu_bus_pkg::*; (
  input logic        clk,
  input logic        rst_n,
  input logic        if_gnt_i,
  input logic        if_err_i,
  input logic        lsu_gnt_i,
  input logic        lsu_err_i,
  input logic        bus_req_i,
  input logic [31:0] bus_addr_i,
  input logic        bus_we_i,
  input logic        bus_dbg_i,
  input memtype_t    bus_memtype_i,
  input logic        bus_gnt_i
);

  // A stalled bus request keeps its fields until granted
  a_bus_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_i && !bus_gnt_i |=> bus_req_i && $stable(bus_addr_i) && $stable(bus_we_i)
      && $stable(bus_dbg_i) && $stable(bus_memtype_i))
    else $error("bus request changed while stalled");

  // Loads are never bufferable
  a_load_not_buf: assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_i && !bus_we_i |-> !bus_memtype_i[MEMTYPE_BUF_BIT])
    else $error("bufferable bit set on a bus read");

  a_if_err_after_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    if_err_i |-> $past(if_gnt_i))
    else $error("fetch error pulse without a grant one cycle earlier");

  a_lsu_err_after_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    lsu_err_i |-> $past(lsu_gnt_i))
    else $error("load/store error pulse without a grant one cycle earlier");

endmodule

`default_nettype wire

// File: tb/tb_mpu_top.sv
`default_nettype none

module tb_mpu_top import mpu_pma_pkg::*, mpu_bus_pkg::*; ();

  localparam int HALF         = 4;
  localparam int RESET_CYCLES = 8;
  localparam int MAX_WAIT     = 32;
  localparam int NUM_ROWS     = 14;
  localparam int NUM_CONT     = 6;  // requests per port under contention

  typedef struct packed {
    logic     lsu;
    addr_t    addr;
    logic     we;
    logic     dbg;
    logic     mis;
    logic     err;
    memtype_t mt;
  } row_t;

  // Columns: lsu port, address, write, debug, misaligned, error, memtype {cache, buf}
  localparam row_t ROWS [NUM_ROWS] = '{
    '{1'b1, 32'h0000_9000, 1'b0, 1'b0, 1'b0, 1'b0, 2'b10},  // region 0 beats region 3
    '{1'b1, 32'h0001_2000, 1'b0, 1'b0, 1'b0, 1'b0, 2'b00},
    '{1'b1, 32'h1000_0010, 1'b0, 1'b0, 1'b0, 1'b0, 2'b00},
    '{1'b1, 32'h2000_0100, 1'b1, 1'b0, 1'b0, 1'b0, 2'b11},
    '{1'b1, 32'h2000_0100, 1'b0, 1'b0, 1'b0, 1'b0, 2'b10},
    '{1'b0, 32'h2000_0100, 1'b0, 1'b0, 1'b0, 1'b0, 2'b10},
    '{1'b0, 32'h1000_0000, 1'b0, 1'b0, 1'b0, 1'b1, 2'b00},
    '{1'b0, 32'h4000_0000, 1'b0, 1'b0, 1'b0, 1'b1, 2'b00},  // unmatched
    '{1'b0, 32'h0001_2000, 1'b0, 1'b0, 1'b0, 1'b1, 2'b00},
    '{1'b1, 32'h1000_0004, 1'b0, 1'b0, 1'b1, 1'b1, 2'b00},
    '{1'b1, 32'h0000_0100, 1'b0, 1'b0, 1'b1, 1'b0, 2'b10},
    '{1'b0, 32'hF000_0010, 1'b0, 1'b1, 1'b0, 1'b0, 2'b00},  // debug window
    '{1'b0, 32'hF000_0010, 1'b0, 1'b0, 1'b0, 1'b1, 2'b00},
    '{1'b1, 32'hF000_0100, 1'b1, 1'b1, 1'b0, 1'b0, 2'b00}
  };

  logic        clk = 1'b0;
  logic        rst_n;
  logic        if_req;
  addr_t       if_addr;
  logic        if_dbg;
  logic        if_gnt;
  logic        if_err;
  logic        lsu_req;
  addr_t       lsu_addr;
  logic        lsu_we;
  logic        lsu_dbg;
  logic        lsu_mis;
  logic        lsu_gnt;
  logic        lsu_err;
  logic        bus_req;
  addr_t       bus_addr;
  logic        bus_we;
  logic        bus_dbg;
  memtype_t    bus_mt;
  logic        bus_gnt = 1'b0;
  logic [31:0] rng = 32'hcc3e;
  logic        test_ok;
  int          pass_cnt = 0;
  int          fail_cnt = 0;

  mpu_top u_mpu_top (
    .clk(clk), .rst_n(rst_n),
    .if_req_i(if_req), .if_addr_i(if_addr), .if_dbg_i(if_dbg),
    .if_gnt_o(if_gnt), .if_err_o(if_err),
    .lsu_req_i(lsu_req), .lsu_addr_i(lsu_addr), .lsu_we_i(lsu_we), .lsu_dbg_i(lsu_dbg),
    .lsu_misaligned_i(lsu_mis), .lsu_gnt_o(lsu_gnt), .lsu_err_o(lsu_err),
    .bus_req_o(bus_req), .bus_addr_o(bus_addr), .bus_we_o(bus_we), .bus_dbg_o(bus_dbg),
    .bus_memtype_o(bus_mt), .bus_gnt_i(bus_gnt)
  );

  bind mpu_top mpu_checker u_mpu_checker (
    .clk(clk), .rst_n(rst_n),
    .if_gnt_i(if_gnt_o), .if_err_i(if_err_o), .lsu_gnt_i(lsu_gnt_o), .lsu_err_i(lsu_err_o),
    .bus_req_i(bus_req_o), .bus_addr_i(bus_addr_o), .bus_we_i(bus_we_o),
    .bus_dbg_i(bus_dbg_o), .bus_memtype_i(bus_memtype_o), .bus_gnt_i(bus_gnt_i)
  );

  always #(HALF) clk = !clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Bus grant is high about three cycles in four
  always @(negedge clk) begin
    rng     = xorshift(rng);
    bus_gnt = (rng[1:0] != 2'b00);
  end

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_err(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
      test_ok = 1'b0;
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
      test_ok = 1'b0;
    end
  endtask

  task automatic check_memtype(input memtype_t got, input memtype_t exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
      test_ok = 1'b0;
    end
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
      test_ok = 1'b0;
    end
  endtask

  function automatic logic port_gnt(input logic lsu);
    return lsu ? lsu_gnt : if_gnt;
  endfunction

  function automatic logic port_err(input logic lsu);
    return lsu ? lsu_err : if_err;
  endfunction

  task automatic drive_row(input row_t r, input logic req);
    if_req   = req && !r.lsu;
    if_addr  = r.addr;
    if_dbg   = r.dbg;
    lsu_req  = req && r.lsu;
    lsu_addr = r.addr;
    lsu_we   = r.we;
    lsu_dbg  = r.dbg;
    lsu_mis  = r.mis;
  endtask

  task automatic finish_test(input string name);
    $display("Test %s %s", name, test_ok ? "passed" : "failed");
    if (test_ok) begin
      pass_cnt++;
    end else begin
      fail_cnt++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  // Sampling one unit before the rising edge sees the values of that edge
  task automatic run_row(input int n);
    row_t r;
    int   wait_cnt;
    r        = ROWS[n];
    wait_cnt = 0;
    test_ok  = 1'b1;
    @(negedge clk);
    drive_row(r, 1'b1);
    #(HALF - 1);
    while (!port_gnt(r.lsu) && wait_cnt < MAX_WAIT) begin
      @(negedge clk);
      #(HALF - 1);
      wait_cnt++;
    end
    if (!port_gnt(r.lsu)) begin
      $display("Row %0d got no grant within %0d cycles", n, MAX_WAIT);
      test_ok = 1'b0;
    end else if (r.err && bus_req) begin
      $display("Row %0d: a refused access reached the bus at %0t", n, $time);
      test_ok = 1'b0;
    end else if (!r.err) begin
      check_addr(bus_addr, r.addr, "bus_addr_o");
      check_memtype(bus_mt, r.mt, "bus_memtype_o");
      // Fetches never write
      check_flag(bus_we, r.lsu && r.we, "bus_we_o");
      check_flag(bus_dbg, r.dbg, "bus_dbg_o");
    end
    @(negedge clk);
    drive_row(r, 1'b0);
    #(HALF - 1);
    check_err(port_err(r.lsu), r.err, "err_o");
    finish_test($sformatf("row %0d at 0x%08h", n, r.addr));
  endtask

  task automatic run_contention();
    int   if_idx;
    int   lsu_idx;
    int   cycles;
    logic exp_lsu;
    if_idx  = 0;
    lsu_idx = 0;
    cycles  = 0;
    exp_lsu = 1'b1;
    test_ok = 1'b1;
    while ((if_idx < NUM_CONT || lsu_idx < NUM_CONT) && cycles < 2 * NUM_CONT * MAX_WAIT) begin
      @(negedge clk);
      if_req   = (if_idx < NUM_CONT);
      if_addr  = 32'h0000_0400 + if_idx * 4;
      if_dbg   = 1'b0;
      lsu_req  = (lsu_idx < NUM_CONT);
      lsu_addr = 32'h2000_1000 + lsu_idx * 16;
      lsu_we   = lsu_idx[0];
      lsu_dbg  = 1'b0;
      lsu_mis  = 1'b0;
      #(HALF - 1);
      if (if_gnt || lsu_gnt) begin
        if (lsu_gnt !== exp_lsu || if_gnt === lsu_gnt) begin
          $display("Grant order broken at %0t", $time);
          test_ok = 1'b0;
        end
        check_addr(bus_addr, lsu_gnt ? lsu_addr : if_addr, "bus_addr_o under contention");
        check_memtype(bus_mt, (lsu_gnt && lsu_we) ? 2'b11 : 2'b10, "bus_memtype_o");
        check_flag(bus_we, lsu_gnt && lsu_we, "bus_we_o under contention");
        check_flag(bus_dbg, 1'b0, "bus_dbg_o under contention");
        if (lsu_gnt) begin
          lsu_idx++;
        end else begin
          if_idx++;
        end
        exp_lsu = !exp_lsu;
      end
      cycles++;
    end
    @(negedge clk);
    if_req  = 1'b0;
    lsu_req = 1'b0;
    if (if_idx < NUM_CONT || lsu_idx < NUM_CONT) begin
      $display("Requests were lost under contention");
      test_ok = 1'b0;
    end
    finish_test("contention");
  endtask

  initial begin
    rst_n = 1'b0;
    drive_row(ROWS[0], 1'b0);
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // Right after reset, so the first tie goes to the load/store port
    run_contention();
    for (int n = 0; n < NUM_ROWS; n++) begin
      run_row(n);
    end
    $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    #((NUM_ROWS + 2 * NUM_CONT) * MAX_WAIT * 2 * HALF + RESET_CYCLES * 2 * HALF);
    $display("Timeout: the tests did not finish in time");
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
source/mpu_pma_pkg.sv
source/mpu_bus_pkg.sv
source/pma_lookup.sv
source/mpu_port.sv
source/bus_arbiter.sv
source/mpu_top.sv
tb/mpu_checker.sv
tb/tb_mpu_top.sv
